// ==== kbd_term.f ====
kbd_term_pkg.sv
ps2_receiver.sv
key_decoder.sv
text_buffer.sv
vga_timing.sv
text_renderer.sv
kbd_term.sv
kbd_term_asserts.sv
kbd_term_tb.sv

// ==== kbd_term.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_term import kbd_term_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   ps2_clk,
  input  logic   ps2_data,
  output video_t video,
  output logic   frame_error
);

  scan_t      scan;
  key_t       key;
  cell_addr_t rd_addr;
  logic [7:0] rd_char;
  scan_pos_t  pos;

  // ----------------------------------------------------------------------
  // Keyboard to buffer
  // ----------------------------------------------------------------------
  ps2_receiver ps2_receiver_inst (
    .clk         (clk),
    .rst         (rst),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .scan        (scan),
    .frame_error (frame_error)
  );

  key_decoder key_decoder_inst (
    .clk  (clk),
    .rst  (rst),
    .scan (scan),
    .key  (key)
  );

  text_buffer text_buffer_inst (
    .clk     (clk),
    .rst     (rst),
    .key     (key),
    .rd_addr (rd_addr),
    .rd_char (rd_char)
  );

  // ----------------------------------------------------------------------
  // Buffer to screen
  // ----------------------------------------------------------------------
  vga_timing vga_timing_inst (
    .clk (clk),
    .rst (rst),
    .pos (pos)
  );

  text_renderer text_renderer_inst (
    .clk     (clk),
    .rst     (rst),
    .pos     (pos),
    .rd_addr (rd_addr),
    .rd_char (rd_char),
    .video   (video)
  );

endmodule

`default_nettype wire

// ==== kbd_term_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_term_asserts import kbd_term_pkg::*; (
  input logic   clk,
  input logic   rst,
  input video_t video,
  input key_t   key
);

  // Syncs sit in blanking only.
  assert property (@(posedge clk) disable iff (rst) video.active |-> video.hsync && video.vsync)
    else $error("sync low during active video");

  assert property (@(posedge clk) disable iff (rst) video.active |-> video.h_addr < 10'(h_active))
    else $error("active set right of the visible area");

  // One strobe per scancode.
  assert property (@(posedge clk) disable iff (rst) key.valid |=> !key.valid)
    else $error("key strobe high two cycles in a row");

endmodule

bind kbd_term kbd_term_asserts kbd_term_asserts_inst (
  .clk   (clk),
  .rst   (rst),
  .video (video),
  .key   (key)
);

`default_nettype wire

// ==== kbd_term_cases.txt ====
// op aa bb cc in hex: 01 key aa gives ascii bb, 02 bad-parity frame aa, 04 enter,
// 05 byte aa that writes nothing, 06 key aa gives ascii bb cc times, 03 cell col aa row bb = cc
011c6100 // a
01163100 // 1
01292000 // space
05f00000 // break prefix
05290000 // space released
05770000 // unmapped code
02320000 // b with bad parity
01326200 // b
04000000 // enter
011a7a00 // z
06357946 // 70 times y, the last wraps to row 2
03000061
03010031
03020020
03030062
03040000
0300017a
03010179
03450179
03000279
03010200

// ==== kbd_term_pkg.sv ====
`default_nettype none

package kbd_term_pkg;

  // ----------------------------------------------------------------------
  // Text grid
  // ----------------------------------------------------------------------
  localparam int cols       = 70;
  localparam int rows       = 30;
  localparam int cell_count = cols * rows; // 2100 cells.
  localparam int cell_w     = 9;
  localparam int cell_h     = 16;
  localparam int text_w     = cols * cell_w; // 630 pixels.

  // ----------------------------------------------------------------------
  // 640x480 VGA timing
  // ----------------------------------------------------------------------
  localparam int h_active = 640;
  localparam int h_front  = 16;
  localparam int h_sync   = 96;
  localparam int h_back   = 48;
  localparam int h_total  = h_active + h_front + h_sync + h_back; // 800.
  localparam int h_sync_start = h_active + h_front;

  localparam int v_active = 480;
  localparam int v_front  = 10;
  localparam int v_sync   = 2;
  localparam int v_back   = 33;
  localparam int v_total  = v_active + v_front + v_sync + v_back; // 525.
  localparam int v_sync_start = v_active + v_front;

  // Keyboard codes.
  localparam logic [7:0] break_prefix = 8'hF0;
  localparam logic [7:0] enter_code   = 8'h5A;
  localparam logic [7:0] blank_char   = 8'h00;

  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } scan_t;

  typedef struct packed {
    logic [7:0] ascii;
    logic       newline;
    logic       valid;
  } key_t;

  typedef struct packed {
    logic [6:0] col;
    logic [4:0] row;
  } cell_addr_t;

  typedef struct packed {
    logic [9:0] h;
    logic [9:0] v;
    logic       active;
    logic       in_text; // Active and left of text_w.
  } scan_pos_t;

  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       active;
    logic [9:0] h_addr;
    logic [9:0] v_addr;
    logic [7:0] char_code;
    logic [3:0] glyph_row;
    logic [3:0] glyph_col;
  } video_t;

endpackage

`default_nettype wire

// ==== kbd_term_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_term_tb import kbd_term_pkg::*; ();

  localparam int frame_cycles = h_total * v_total; // One VGA frame.
  localparam int ps2_cycles   = 150;               // One PS/2 frame with its gap.

  logic   clk;
  logic   rst;
  logic   ps2_clk;
  logic   ps2_data;
  video_t video;
  logic   frame_error;

  logic [31:0] cases [64];
  logic [7:0]  model [cell_count];
  int unsigned cycles;
  int unsigned limit;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          error_pulses;

  kbd_term kbd_term_inst (
    .clk         (clk),
    .rst         (rst),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .video       (video),
    .frame_error (frame_error)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Watchdog and frame error counter
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Something failed");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (!rst && frame_error) error_pulses <= error_pulses + 1;
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_char(input string name, input logic [7:0] actual,
                            input logic [7:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_glyph(input string name, input logic [3:0] actual,
                             input logic [3:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_sync(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic check_addr(input string name, input logic [9:0] actual,
                            input logic [9:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s", name);
    end
  endtask

  // Start, 8 data bits LSB first, odd parity, stop. 10 clk per bit.
  task automatic send_frame(input logic [7:0] code, input bit bad_parity);
    logic [10:0] bits;
    logic        parity;
    parity = ~^code;
    if (bad_parity) parity = ~parity;
    bits = {1'b1, parity, code, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 11; i++) begin
      ps2_data <= bits[i];
      repeat (5) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (5) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    repeat (20) @(posedge clk);
  endtask

  // Reference cursor: write, step, wrap at column 69 and row 29.
  task automatic model_key(input logic [7:0] ascii, input bit newline,
                           inout int col, inout int row);
    if (!newline) model[row * cols + col] = ascii;
    if (newline || col == cols - 1) begin
      col = 0;
      row = (row == rows - 1) ? 0 : row + 1;
    end else begin
      col = col + 1;
    end
  endtask

  task automatic wait_pixel(input int h, input int v);
    @(negedge clk);
    while (!(video.active && video.h_addr == 10'(h) && video.v_addr == 10'(v))) @(negedge clk);
  endtask

  initial begin
    logic [7:0] op;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    int         cur_col;
    int         cur_row;
    int         n_expect;
    int         n_frames;
    int         n_bad;
    int         err_before;
    int         hs_low;
    int         vs_low;
    int         px_h;
    int         px_v;
    logic [7:0] exp_char;

    rst      = 1'b1;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    cycles   = 0;
    limit    = 0;
    errors   = 0;
    tests_passed = 0;
    tests_failed = 0;
    error_pulses = 0;
    cur_col  = 0;
    cur_row  = 0;
    n_expect = 0;
    n_frames = 0;
    n_bad    = 0;
    foreach (cases[i]) cases[i] = '0;
    foreach (model[i]) model[i] = 8'h00;
    $readmemh("kbd_term_cases.txt", cases);

    foreach (cases[i]) begin
      case (cases[i][31:24])
        8'h01, 8'h02, 8'h04, 8'h05: n_frames++;
        8'h03: n_expect++;
        8'h06: n_frames += int'(cases[i][7:0]);
        default: ;
      endcase
    end
    limit = (n_expect + 5) * frame_cycles + n_frames * ps2_cycles * 2 + 2200;

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (2200) @(posedge clk); // Clear sweep.

    // ----------------------------------------------------------------------
    // Case file
    // ----------------------------------------------------------------------
    foreach (cases[i]) begin
      {op, a, b, c} = cases[i];
      case (op)
        8'h01: begin
          send_frame(a, 1'b0);
          model_key(b, 1'b0, cur_col, cur_row);
        end
        8'h02: begin
          send_frame(a, 1'b1);
          n_bad++;
        end
        8'h04: begin
          send_frame(enter_code, 1'b0);
          model_key(8'h00, 1'b1, cur_col, cur_row);
        end
        8'h05: send_frame(a, 1'b0);
        8'h06: begin
          for (int k = 0; k < int'(c); k++) begin
            send_frame(a, 1'b0);
            model_key(b, 1'b0, cur_col, cur_row);
          end
        end
        8'h03: begin
          err_before = errors;
          if (model[int'(b) * cols + int'(a)] !== c) begin
            errors++;
            $display("Case file expects %h at %0d,%0d but the cursor model holds %h",
                     c, a, b, model[int'(b) * cols + int'(a)]);
          end
          wait_pixel(int'(a) * cell_w, int'(b) * cell_h);
          check_char("video.char_code", video.char_code, c);
          finish_test($sformatf("cell %0d,%0d", a, b), err_before);
        end
        default: ;
      endcase
    end

    err_before = errors;
    if (error_pulses != n_bad) begin
      errors++;
      $display("Saw %0d frame_error pulses where %0d bad frames were sent", error_pulses, n_bad);
    end
    finish_test("frame errors", err_before);

    // One whole active line through row 1, glyph row 5.
    err_before = errors;
    wait_pixel(0, cell_h + 5);
    for (int h = 0; h < h_active; h++) begin
      exp_char = (h < text_w) ? model[cols + h / cell_w] : 8'h00;
      check_char("video.char_code", video.char_code, exp_char);
      check_glyph("video.glyph_col", video.glyph_col, (h < text_w) ? 4'(h % cell_w) : 4'h0);
      check_glyph("video.glyph_row", video.glyph_row, (h < text_w) ? 4'd5 : 4'h0);
      @(negedge clk);
    end
    finish_test("pixel fields on one line", err_before);

    // ----------------------------------------------------------------------
    // Sync timing over one full frame
    // ----------------------------------------------------------------------
    err_before = errors;
    hs_low = 0;
    vs_low = 0;
    wait_pixel(0, 0);
    for (int n = 0; n < frame_cycles; n++) begin
      px_h = n % h_total;
      px_v = n / h_total;
      check_addr("video.h_addr", video.h_addr, 10'(px_h));
      check_addr("video.v_addr", video.v_addr, 10'(px_v));
      check_flag("video.active", video.active, px_h < h_active && px_v < v_active);
      check_sync("video.hsync", video.hsync,
                 !(px_h >= h_active + h_front && px_h < h_active + h_front + h_sync));
      check_sync("video.vsync", video.vsync,
                 !(px_v >= v_active + v_front && px_v < v_active + v_front + v_sync));
      if (!video.hsync) hs_low++;
      if (!video.vsync) vs_low++;
      @(negedge clk);
    end
    if (hs_low != h_sync * v_total || vs_low != v_sync * h_total) begin
      errors++;
      $display("Sync low for %0d and %0d cycles in one frame", hs_low, vs_low);
    end
    finish_test("sync timing", err_before);

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== key_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_decoder import kbd_term_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  scan_t scan,
  output key_t  key
);

  logic       break_pending;
  logic       mapped;
  logic [7:0] ascii;
  logic       key_valid;
  logic       key_newline;
  logic [7:0] key_ascii;

  // ----------------------------------------------------------------------
  // Make code to lower-case ASCII
  // ----------------------------------------------------------------------
  always_comb begin
    mapped = 1'b1;
    case (scan.data)
      8'h1C: ascii = "a";
      8'h32: ascii = "b";
      8'h21: ascii = "c";
      8'h23: ascii = "d";
      8'h24: ascii = "e";
      8'h2B: ascii = "f";
      8'h34: ascii = "g";
      8'h33: ascii = "h";
      8'h43: ascii = "i";
      8'h3B: ascii = "j";
      8'h42: ascii = "k";
      8'h4B: ascii = "l";
      8'h3A: ascii = "m";
      8'h31: ascii = "n";
      8'h44: ascii = "o";
      8'h4D: ascii = "p";
      8'h15: ascii = "q";
      8'h2D: ascii = "r";
      8'h1B: ascii = "s";
      8'h2C: ascii = "t";
      8'h3C: ascii = "u";
      8'h2A: ascii = "v";
      8'h1D: ascii = "w";
      8'h22: ascii = "x";
      8'h35: ascii = "y";
      8'h1A: ascii = "z";
      8'h45: ascii = "0";
      8'h16: ascii = "1";
      8'h1E: ascii = "2";
      8'h26: ascii = "3";
      8'h25: ascii = "4";
      8'h2E: ascii = "5";
      8'h36: ascii = "6";
      8'h3D: ascii = "7";
      8'h3E: ascii = "8";
      8'h46: ascii = "9";
      8'h29: ascii = " ";
      enter_code: ascii = 8'h0D; // Carriage return.
      default: begin
        ascii  = 8'h00;
        mapped = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      break_pending <= 1'b0;
      key_valid     <= 1'b0;
    end else begin
      key_valid <= 1'b0;
      if (scan.valid) begin
        if (scan.data == break_prefix) begin
          break_pending <= 1'b1;
        end else if (break_pending) begin
          break_pending <= 1'b0; // Released key, drop it.
        end else begin
          key_valid <= mapped;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (scan.valid) begin
      key_ascii   <= ascii;
      key_newline <= (scan.data == enter_code);
    end
  end

  assign key = '{ascii: key_ascii, newline: key_newline, valid: key_valid};

endmodule

`default_nettype wire

// ==== ps2_receiver.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_receiver import kbd_term_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  ps2_clk,
  input  logic  ps2_data,
  output scan_t scan,
  output logic  frame_error
);

  logic [2:0] clk_sync;
  logic [2:0] data_sync;
  logic       clk_fall;
  logic       bit_in;
  logic [3:0] bit_cnt;
  logic [9:0] shift;  // Parity, data, start once full.
  logic       frame_ok;
  logic       scan_valid;
  logic [7:0] scan_data;

  // Both lines idle high.
  always_ff @(posedge clk) begin
    if (rst) begin
      clk_sync  <= 3'b111;
      data_sync <= 3'b111;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk};
      data_sync <= {data_sync[1:0], ps2_data};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];
  assign bit_in   = data_sync[1];

  // Start low, stop high, odd parity over data and parity bit.
  assign frame_ok = ~shift[0] & bit_in & (^shift[9:1]);

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt     <= '0;
      scan_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      scan_valid  <= 1'b0;
      frame_error <= 1'b0;
      if (clk_fall) begin
        if (bit_cnt == 4'd10) begin // Stop bit.
          bit_cnt     <= '0;
          scan_valid  <= frame_ok;
          frame_error <= ~frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clk_fall && bit_cnt != 4'd10) shift <= {bit_in, shift[9:1]}; // LSB first.
    if (clk_fall && bit_cnt == 4'd10) scan_data <= shift[8:1];
  end

  assign scan = '{data: scan_data, valid: scan_valid};

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f kbd_term.f --top-module kbd_term_tb \
  -o kbd_term_sim
out=$(./obj_dir/kbd_term_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// ==== text_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module text_buffer import kbd_term_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  key_t       key,
  input  cell_addr_t rd_addr,
  output logic [7:0] rd_char
);

  logic [7:0]  mem [cell_count];
  logic        clearing;
  logic [11:0] clear_idx;
  cell_addr_t  cursor;
  logic        wr_en;
  logic [11:0] wr_idx;
  logic [7:0]  wr_data;

  // Row-major cell index.
  function automatic logic [11:0] cell_index(cell_addr_t a);
    return 12'(a.row) * 12'(cols) + 12'(a.col);
  endfunction

  // ----------------------------------------------------------------------
  // Clear sweep and cursor
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      clearing  <= 1'b1;
      clear_idx <= '0;
      cursor    <= '0;
    end else if (clearing) begin
      if (clear_idx == 12'(cell_count - 1)) clearing <= 1'b0;
      clear_idx <= clear_idx + 12'd1;
    end else if (key.valid) begin
      if (key.newline || cursor.col == 7'(cols - 1)) begin
        cursor.col <= '0;
        cursor.row <= (cursor.row == 5'(rows - 1)) ? '0 : cursor.row + 5'd1;
      end else begin
        cursor.col <= cursor.col + 7'd1;
      end
    end
  end

  // Single write port, sweep has priority.
  always_comb begin
    if (clearing) begin
      wr_en   = 1'b1;
      wr_idx  = clear_idx;
      wr_data = blank_char;
    end else begin
      wr_en   = key.valid & ~key.newline;
      wr_idx  = cell_index(cursor);
      wr_data = key.ascii;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_idx] <= wr_data;
  end

  // Registered read, one cycle.
  always_ff @(posedge clk) begin
    rd_char <= mem[cell_index(rd_addr)];
  end

endmodule

`default_nettype wire

// ==== text_renderer.sv ====
`timescale 1ns/1ns
`default_nettype none

module text_renderer import kbd_term_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  scan_pos_t  pos,
  output cell_addr_t rd_addr,
  input  logic [7:0] rd_char,
  output video_t     video
);

  // Cell counters run in step with pos.
  logic [6:0] cell_col;
  logic [5:0] cell_row;  // Reaches 32 in vertical blanking.
  logic [3:0] glyph_col;
  logic [3:0] glyph_row;
  logic       hsync_n;
  logic       vsync_n;
  video_t     s1;
  logic       s1_in_text;

  always_ff @(posedge clk) begin
    if (rst) begin
      cell_col  <= '0;
      cell_row  <= '0;
      glyph_col <= '0;
      glyph_row <= '0;
    end else if (pos.h == 10'(h_total - 1)) begin
      cell_col  <= '0;
      glyph_col <= '0;
      if (pos.v == 10'(v_total - 1)) begin
        cell_row  <= '0;
        glyph_row <= '0;
      end else if (glyph_row == 4'(cell_h - 1)) begin
        cell_row  <= cell_row + 6'd1;
        glyph_row <= '0;
      end else begin
        glyph_row <= glyph_row + 4'd1;
      end
    end else if (glyph_col == 4'(cell_w - 1)) begin
      cell_col  <= cell_col + 7'd1;
      glyph_col <= '0;
    end else begin
      glyph_col <= glyph_col + 4'd1;
    end
  end

  assign rd_addr = '{col: cell_col, row: cell_row[4:0]};

  assign hsync_n = !((pos.h >= 10'(h_sync_start)) && (pos.h < 10'(h_sync_start + h_sync)));
  assign vsync_n = !((pos.v >= 10'(v_sync_start)) && (pos.v < 10'(v_sync_start + v_sync)));

  // ----------------------------------------------------------------------
  // Stage 1 runs alongside the buffer read, stage 2 merges the char
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      s1         <= '{hsync: 1'b1, vsync: 1'b1, default: '0};
      s1_in_text <= 1'b0;
    end else begin
      s1 <= '{hsync: hsync_n, vsync: vsync_n, active: pos.active, h_addr: pos.h,
              v_addr: pos.v, char_code: 8'h00, glyph_row: glyph_row, glyph_col: glyph_col};
      s1_in_text <= pos.in_text;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      video <= '{hsync: 1'b1, vsync: 1'b1, default: '0};
    end else begin
      video           <= s1;
      video.char_code <= s1_in_text ? rd_char : 8'h00;
      video.glyph_row <= s1_in_text ? s1.glyph_row : 4'h0;
      video.glyph_col <= s1_in_text ? s1.glyph_col : 4'h0;
    end
  end

endmodule

`default_nettype wire

// ==== vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_timing import kbd_term_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  output scan_pos_t pos
);

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       line_end;
  logic       frame_end;
  logic       active;
  logic       in_text;

  assign line_end  = (h_cnt == 10'(h_total - 1));
  assign frame_end = (v_cnt == 10'(v_total - 1));

  // ----------------------------------------------------------------------
  // Counters, 800 cycles by 525 lines
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v_cnt <= '0;
    end else if (line_end) begin
      v_cnt <= frame_end ? '0 : v_cnt + 10'd1;
    end
  end

  assign active  = (h_cnt < 10'(h_active)) && (v_cnt < 10'(v_active));
  assign in_text = active && (h_cnt < 10'(text_w)); // Right margin is blank.

  assign pos = '{h: h_cnt, v: v_cnt, active: active, in_text: in_text};

endmodule

`default_nettype wire
